// File: d2h_fis_tagger.sv
// Tags words from the link as head or body and appends one status word
// (OK or ERR, zero data) one cycle after a received FIS ends.
// The link must not deliver a data word in the cycle the status word is pushed.
`timescale 1ns/100ps

module d2h_fis_tagger (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     rx_valid,         // data word from link
    input  logic [pkg_sata_xport::DWORD_W-1:0]       rx_data,
    input  logic                                     incom_start,      // FIS begins
    input  logic                                     incom_done,       // FIS ended clean
    input  logic                                     incom_invalidate, // FIS ended bad
    output logic                                     push,             // write to d2h FIFO
    output pkg_sata_xport::d2h_word_t                push_word
);

    pkg_sata_xport::d2h_type_e tag;     // tag for the next word
    logic                      fis_end;
    logic                      status_push;  // delayed end-of-FIS write

    assign fis_end = incom_done || incom_invalidate;

    always_ff @(posedge clk) begin
        if (rst) begin
            tag         <= pkg_sata_xport::D2H_HEAD;
            status_push <= 1'b0;
        end else begin
            if (incom_start) begin
                tag <= pkg_sata_xport::D2H_HEAD;
            end else if (rx_valid) begin
                tag <= pkg_sata_xport::D2H_DATA;          // body from now on
            end else if (fis_end) begin
                tag <= incom_invalidate ? pkg_sata_xport::D2H_ERR
                                        : pkg_sata_xport::D2H_OK;
            end
            // only after data, so a second done cannot append again
            status_push <= fis_end && (tag == pkg_sata_xport::D2H_DATA);
        end
    end

    // tag already holds OK/ERR when the status word goes out
    always_comb begin
        push           = rx_valid || status_push;
        push_word.kind = tag;
        push_word.data = status_push ? '0 : rx_data;
    end

    // end of FIS is its own cycle, never carries a word
    a_end_no_data: assert property (
        @(posedge clk) disable iff (rst)
        !(fis_end && rx_valid)
    ) else $error("d2h_fis_tagger: incom_done/invalidate together with rx_valid");

    // status word must not collide with a new data word
    a_status_alone: assert property (
        @(posedge clk) disable iff (rst)
        status_push |-> !rx_valid
    ) else $error("d2h_fis_tagger: rx_valid in status push cycle, word dropped");

endmodule

// File: flist.f
pkg_sata_xport.sv
sata_word_fifo.sv
h2d_frame_gate.sv
d2h_fis_tagger.sv
sata_xport_buffers.sv
tb_sata_xport.sv

// File: h2d_frame_gate.sv
// Requests a link frame for a host FIS once it is fully buffered or enough
// words are waiting. START_BITS must not exceed FIFO_AW. A head word that
// arrives in the very cycle a request is issued is not tracked as pending.
`timescale 1ns/100ps

module h2d_frame_gate #(
    parameter int FIFO_AW    = pkg_sata_xport::DEF_FIFO_AW,
    parameter int START_BITS = pkg_sata_xport::DEF_START_BITS
)(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr,          // host word written this cycle
    input  pkg_sata_xport::h2d_type_e wr_kind,     // tag of that word
    input  logic [FIFO_AW:0]          fill,        // h2d words before this write
    input  logic                      frame_busy,  // link cannot take a request
    output logic                      frame_req    // one-cycle pulse to link
);

    logic pending;                 // head seen, no request yet
    logic head_wr;
    logic last_wr;
    logic enough;                  // fill >= 2**START_BITS
    logic req_next;

    assign head_wr = wr && (wr_kind == pkg_sata_xport::H2D_HEAD);
    assign last_wr = wr && (wr_kind == pkg_sata_xport::H2D_LAST);
    assign enough  = |fill[FIFO_AW:START_BITS];   // any bit at or above start level

    // whole FIS in, or enough to keep the link fed
    assign req_next = !frame_busy && pending && (last_wr || enough);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending   <= 1'b0;
            frame_req <= 1'b0;
        end else begin
            frame_req <= req_next;
            if (req_next) begin
                pending <= 1'b0;   // clear as the request registers
            end else if (head_wr) begin
                pending <= 1'b1;
            end
        end
    end

    // pending drops with the request, so it can never repeat back to back
    a_req_single: assert property (
        @(posedge clk) disable iff (rst)
        frame_req |=> !frame_req
    ) else $error("h2d_frame_gate: frame_req high on two consecutive cycles");

endmodule

// File: pkg_sata_xport.sv
// Shared word formats and default sizes for the SATA transport buffers.
// Tags sit above the data in each word. Only full 32-bit words are carried,
// there is no byte mask.
package pkg_sata_xport;

    localparam int DWORD_W        = 32;  // one SATA dword
    localparam int DEF_FIFO_AW    = 9;   // 512-word FIFOs
    localparam int DEF_START_BITS = 6;   // start tx at 64 buffered words

    localparam int H2D_HEADROOM   = 8;   // host may send while this much is free
    localparam int D2H_HEADROOM   = 64;  // tell link busy below this much free
    localparam int MANY_LEVEL     = 8;   // d2h_many threshold

    // host -> device word tag
    typedef enum logic [1:0] {
        H2D_DATA = 2'd0,                 // FIS body
        H2D_HEAD = 2'd1,                 // first word of a FIS
        H2D_LAST = 2'd2                  // final word of a FIS
    } h2d_type_e;

    // device -> host word tag
    typedef enum logic [1:0] {
        D2H_DATA = 2'd0,                 // FIS body
        D2H_HEAD = 2'd1,                 // first received word
        D2H_OK   = 2'd2,                 // status, FIS received clean
        D2H_ERR  = 2'd3                  // status, FIS invalidated
    } d2h_type_e;

    // status words carry zero data, so the host
    // should look only at the kind for OK/ERR

    typedef struct packed {
        h2d_type_e            kind;      // 2 bits
        logic [DWORD_W-1:0]   data;      // payload dword
    } h2d_word_t;                        // 34 bits total

    typedef struct packed {
        d2h_type_e            kind;      // 2 bits
        logic [DWORD_W-1:0]   data;      // payload or zero on status
    } d2h_word_t;                        // 34 bits total

endpackage

// File: run.sh
#!/bin/sh
# Verilator build and run of the SATA transport buffer testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sata_xport -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// File: sata_word_fifo.sv
// Single clock show-ahead FIFO, head word is readable with no read latency.
// Writes into a full FIFO and reads from an empty one are dropped, and the
// assertions below flag both. room is high while at least HEADROOM words are free.
`timescale 1ns/100ps

module sata_word_fifo #(
    parameter int  FIFO_AW   = pkg_sata_xport::DEF_FIFO_AW,  // depth is 2**FIFO_AW
    parameter int  HEADROOM  = 8,                            // free words for room
    parameter type payload_t = pkg_sata_xport::h2d_word_t    // stored word type
)(
    input  logic             clk,
    input  logic             rst,
    input  logic             wr,          // push wr_word this cycle
    input  payload_t         wr_word,
    input  logic             rd,          // pop head word this cycle
    output payload_t         rd_word,     // current head, valid with not_empty
    output logic             not_empty,
    output logic [FIFO_AW:0] fill,        // words held
    output logic             room         // free space >= HEADROOM
);

    localparam int DEPTH = 1 << FIFO_AW;

    payload_t              mem [DEPTH];   // storage, no reset
    logic [FIFO_AW-1:0]    wr_ptr;
    logic [FIFO_AW-1:0]    rd_ptr;
    logic [FIFO_AW:0]      free_cnt;      // DEPTH - fill
    logic                  full;
    logic                  do_wr;         // accepted write
    logic                  do_rd;         // accepted read

    assign full     = fill[FIFO_AW];      // fill == DEPTH
    assign do_wr    = wr && !full;        // overflow words are lost
    assign do_rd    = rd && not_empty;
    assign free_cnt = (FIFO_AW+1)'(DEPTH) - fill;

    assign not_empty = |fill;
    assign room      = free_cnt >= (FIFO_AW+1)'(HEADROOM);
    assign rd_word   = mem[rd_ptr];       // show-ahead head

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at DEPTH
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;    // none, or write and read together
            endcase
        end
    end

    // producer must honour room/busy, otherwise data goes missing
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst)
        !(wr && full)
    ) else $error("sata_word_fifo: write while full, word lost");

    // consumer gates its read with not_empty
    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst)
        !(rd && !not_empty)
    ) else $error("sata_word_fifo: read while empty");

endmodule

// File: sata_xport_buffers.sv
// Transport buffering between host DMA and the SATA link layer.
// Host writes on every cycle with h2d_valid, so it must watch h2d_ready.
// Link words arriving while the d2h FIFO is full are lost.
`timescale 1ns/100ps

module sata_xport_buffers #(
    parameter int FIFO_AW    = pkg_sata_xport::DEF_FIFO_AW,
    parameter int START_BITS = pkg_sata_xport::DEF_START_BITS
)(
    input  logic                               clk,
    input  logic                               rst,
    // host -> device
    input  pkg_sata_xport::h2d_word_t          h2d_in,
    input  logic                               h2d_valid,
    output logic                               h2d_ready,   // >= 8 words free
    // toward link
    output logic [pkg_sata_xport::DWORD_W-1:0] tx_word,
    output logic                               tx_last,
    output logic                               tx_valid,
    input  logic                               tx_strobe,   // link takes head word
    output logic                               frame_req,
    input  logic                               frame_busy,
    // from link
    input  logic                               rx_valid,
    input  logic [pkg_sata_xport::DWORD_W-1:0] rx_data,
    input  logic                               incom_start,
    input  logic                               incom_done,
    input  logic                               incom_invalidate,
    output logic                               link_busy,   // d2h almost full
    // device -> host
    output pkg_sata_xport::d2h_word_t          d2h_out,
    output logic                               d2h_valid,
    output logic                               d2h_many,
    input  logic                               d2h_ready
);

    pkg_sata_xport::h2d_word_t h2d_head;   // h2d FIFO head
    logic [FIFO_AW:0]          h2d_fill;
    logic                      h2d_rd;
    logic                      d2h_push;
    pkg_sata_xport::d2h_word_t d2h_push_word;
    logic [FIFO_AW:0]          d2h_fill;
    logic                      d2h_room;
    logic                      d2h_rd;

    assign h2d_rd   = tx_valid && tx_strobe;
    assign tx_word  = h2d_head.data;
    assign tx_last  = (h2d_head.kind == pkg_sata_xport::H2D_LAST);

    assign d2h_rd    = d2h_valid && d2h_ready;
    assign link_busy = !d2h_room;
    assign d2h_many  = d2h_fill >= (FIFO_AW+1)'(pkg_sata_xport::MANY_LEVEL);

    sata_word_fifo #(
        .FIFO_AW   (FIFO_AW),
        .HEADROOM  (pkg_sata_xport::H2D_HEADROOM),
        .payload_t (pkg_sata_xport::h2d_word_t)
    ) h2d_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (h2d_valid),      // every valid cycle is a write
        .wr_word   (h2d_in),
        .rd        (h2d_rd),
        .rd_word   (h2d_head),
        .not_empty (tx_valid),
        .fill      (h2d_fill),
        .room      (h2d_ready)
    );

    h2d_frame_gate #(
        .FIFO_AW    (FIFO_AW),
        .START_BITS (START_BITS)
    ) frame_gate (
        .clk        (clk),
        .rst        (rst),
        .wr         (h2d_valid),
        .wr_kind    (h2d_in.kind),
        .fill       (h2d_fill),      // level before this write
        .frame_busy (frame_busy),
        .frame_req  (frame_req)
    );

    d2h_fis_tagger fis_tagger (
        .clk              (clk),
        .rst              (rst),
        .rx_valid         (rx_valid),
        .rx_data          (rx_data),
        .incom_start      (incom_start),
        .incom_done       (incom_done),
        .incom_invalidate (incom_invalidate),
        .push             (d2h_push),
        .push_word        (d2h_push_word)
    );

    sata_word_fifo #(
        .FIFO_AW   (FIFO_AW),
        .HEADROOM  (pkg_sata_xport::D2H_HEADROOM),
        .payload_t (pkg_sata_xport::d2h_word_t)
    ) d2h_fifo (
        .clk       (clk),
        .rst       (rst),
        .wr        (d2h_push),
        .wr_word   (d2h_push_word),
        .rd        (d2h_rd),
        .rd_word   (d2h_out),
        .not_empty (d2h_valid),
        .fill      (d2h_fill),
        .room      (d2h_room)        // low means link must pause
    );

endmodule

// File: tb_sata_xport.sv
// Random host and link traffic checked against queue models of both FIFOs.
// Runs NUM_FIS FISes each way, then drains. Model thresholds assume 512-word FIFOs.
// Link FISes always carry at least one word and keep a gap after each end pulse.
`timescale 1ns/100ps

module tb_sata_xport;

    localparam int FIFO_AW     = 9;
    localparam int START_BITS  = 6;
    localparam int DEPTH       = 1 << FIFO_AW;
    localparam int NUM_FIS     = 200;                    // per direction
    localparam int WATCHDOG_NS = NUM_FIS * 120 * 8 * 4;  // fis x words x cycles x period

    typedef enum int {LINK_IDLE, LINK_DATA, LINK_END} link_state_e;

    logic                               clk = 1'b0;
    logic                               rst;
    pkg_sata_xport::h2d_word_t          h2d_in;
    logic                               h2d_valid;
    logic                               h2d_ready;
    logic [pkg_sata_xport::DWORD_W-1:0] tx_word;
    logic                               tx_last;
    logic                               tx_valid;
    logic                               tx_strobe;
    logic                               frame_req;
    logic                               frame_busy;
    logic                               rx_valid;
    logic [pkg_sata_xport::DWORD_W-1:0] rx_data;
    logic                               incom_start;
    logic                               incom_done;
    logic                               incom_invalidate;
    logic                               link_busy;
    pkg_sata_xport::d2h_word_t          d2h_out;
    logic                               d2h_valid;
    logic                               d2h_many;
    logic                               d2h_ready;

    sata_xport_buffers #(.FIFO_AW(FIFO_AW), .START_BITS(START_BITS)) dut (.*);

    logic [31:0]               tx_q[$];       // expected tx words, oldest first
    bit                        last_q[$];     // matching tx_last flags
    pkg_sata_xport::d2h_word_t rx_q[$];       // expected d2h words
    pkg_sata_xport::d2h_word_t status_word;   // status waiting on the tagger delay
    bit                        status_due;
    bit                        pending_m;     // mirror of gate pending
    bit                        req_m;         // predicted frame_req
    bit                        busy_d;        // frame_busy one cycle back
    int                        errors;
    int                        host_fis;
    int                        host_left;     // words left in current host FIS
    int                        host_idx;
    int                        link_fis;
    int                        link_left;
    int                        link_gap;
    bit                        link_first;
    bit                        link_err;
    link_state_e               link_state;
    int                        strobe_pct;    // tx_strobe rate
    int                        ready_pct;     // d2h_ready rate

    always #2 clk = ~clk;                     // 4 ns period

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all FISes were drained and checked");
        $display("Errors found");
        $fatal(1, "timeout");
    end

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0b, actual %0b", name, exp, act);
            $display("Errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_h2d(input string name, input logic [31:0] exp_data,
                             input logic exp_last, input logic [31:0] act_data,
                             input logic act_last);
        if (act_data !== exp_data || act_last !== exp_last) begin
            errors++;
            $display("FAILED %s: expected %h last %0b, actual %h last %0b",
                     name, exp_data, exp_last, act_data, act_last);
            $display("Errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic check_d2h(input string name, input pkg_sata_xport::d2h_word_t exp,
                             input pkg_sata_xport::d2h_word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected kind %0d data %h, actual kind %0d data %h",
                     name, exp.kind, exp.data, act.kind, act.data);
            $display("Errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic int pick_rate();
        int r;
        r = int'($urandom % 3);
        return (r == 0) ? 10 : (r == 1) ? 50 : 95;   // slow phases fill the FIFOs
    endfunction

    // outputs are all register driven, stable half a ns after the edge
    task automatic check_outputs();
        check_flag("frame_req after busy", 1'b0, frame_req && busy_d);
        check_flag("frame_req", req_m, frame_req);
        check_flag("tx_valid", tx_q.size() != 0, tx_valid);
        if (tx_q.size() != 0) begin
            check_h2d("tx order", tx_q[0], last_q[0], tx_word, tx_last);
        end
        check_flag("h2d_ready", (DEPTH - tx_q.size()) >= pkg_sata_xport::H2D_HEADROOM,
                   h2d_ready);
        check_flag("d2h_valid", rx_q.size() != 0, d2h_valid);
        if (rx_q.size() != 0) begin
            check_d2h("rx tagging", rx_q[0], d2h_out);
        end
        check_flag("d2h_many", rx_q.size() >= pkg_sata_xport::MANY_LEVEL, d2h_many);
        check_flag("link_busy", (DEPTH - rx_q.size()) < pkg_sata_xport::D2H_HEADROOM,
                   link_busy);
    endtask

    task automatic drive_host();
        h2d_valid = 1'b0;
        if (host_fis < NUM_FIS && h2d_ready && ($urandom % 4) != 0) begin
            if (host_left == 0) begin
                host_left = 1 + int'($urandom % 100);   // new FIS, 1..100 words
                host_idx  = 0;
            end
            h2d_in.kind = (host_idx == 0)  ? pkg_sata_xport::H2D_HEAD :
                          (host_left == 1) ? pkg_sata_xport::H2D_LAST :
                                             pkg_sata_xport::H2D_DATA;
            h2d_in.data = $urandom;
            h2d_valid   = 1'b1;
            host_idx++;
            host_left--;
            if (host_left == 0) begin
                host_fis++;
            end
        end
    endtask

    // link tx side and the gate mirror, fill seen here is before this write
    task automatic drive_tx_side();
        bit head_wr;
        bit last_wr;
        bit req_next;
        frame_busy = ($urandom % 4) == 0;
        tx_strobe  = ($urandom % 100) < strobe_pct;
        head_wr    = h2d_valid && (h2d_in.kind == pkg_sata_xport::H2D_HEAD);
        last_wr    = h2d_valid && (h2d_in.kind == pkg_sata_xport::H2D_LAST);
        req_next   = !frame_busy && pending_m &&
                     (last_wr || tx_q.size() >= (1 << START_BITS));
        if (req_next) begin
            pending_m = 1'b0;                       // request wins over a new head
        end else if (head_wr) begin
            pending_m = 1'b1;
        end
        req_m  = req_next;
        busy_d = frame_busy;
        if (tx_strobe && tx_q.size() != 0) begin
            void'(tx_q.pop_front());
            void'(last_q.pop_front());
        end
        if (h2d_valid) begin
            tx_q.push_back(h2d_in.data);
            last_q.push_back(h2d_in.kind == pkg_sata_xport::H2D_LAST);
        end
    endtask

    task automatic drive_link();
        pkg_sata_xport::d2h_word_t w;
        rx_valid         = 1'b0;
        incom_start      = 1'b0;
        incom_done       = 1'b0;
        incom_invalidate = 1'b0;
        d2h_ready        = ($urandom % 100) < ready_pct;
        if (d2h_ready && rx_q.size() != 0) begin
            void'(rx_q.pop_front());
        end
        if (status_due) begin                       // tagger writes it at the coming edge
            rx_q.push_back(status_word);
            status_due = 1'b0;
        end
        case (link_state)
            LINK_IDLE: begin
                if (link_gap != 0) begin
                    link_gap--;
                end else if (link_fis < NUM_FIS) begin
                    incom_start = 1'b1;
                    link_left   = 1 + int'($urandom % 80);
                    link_first  = 1'b1;
                    link_state  = LINK_DATA;
                end
            end
            LINK_DATA: begin
                if (!link_busy && ($urandom % 3) != 0) begin   // pause while busy
                    rx_valid = 1'b1;
                    rx_data  = $urandom;
                    w.kind   = link_first ? pkg_sata_xport::D2H_HEAD
                                          : pkg_sata_xport::D2H_DATA;
                    w.data   = rx_data;
                    rx_q.push_back(w);
                    link_first = 1'b0;
                    link_left--;
                    if (link_left == 0) begin
                        link_state = LINK_END;
                    end
                end
            end
            default: begin                          // end pulse, own cycle
                link_err         = ($urandom % 4) == 0;
                incom_done       = !link_err;
                incom_invalidate = link_err;
                status_word.kind = link_err ? pkg_sata_xport::D2H_ERR
                                            : pkg_sata_xport::D2H_OK;
                status_word.data = '0;
                status_due       = 1'b1;
                link_fis++;
                link_gap   = 1 + int'($urandom % 8); // keeps status cycle free of data
                link_state = LINK_IDLE;
            end
        endcase
    endtask

    initial begin
        int cycle;
        bit done;
        void'($urandom(32'h9646_6b05));             // single seed for the run
        rst = 1'b1;
        h2d_in = '0;
        h2d_valid = 1'b0;
        tx_strobe = 1'b0;
        frame_busy = 1'b0;
        rx_valid = 1'b0;
        rx_data = '0;
        incom_start = 1'b0;
        incom_done = 1'b0;
        incom_invalidate = 1'b0;
        d2h_ready = 1'b0;
        link_state = LINK_IDLE;
        link_gap = 4;
        strobe_pct = 50;
        ready_pct = 50;
        repeat (8) begin
            @(posedge clk);
            #0.5;
            check_flag("reset frame_req", 1'b0, frame_req);
            check_flag("reset tx_valid", 1'b0, tx_valid);
            check_flag("reset d2h_valid", 1'b0, d2h_valid);
            check_flag("reset h2d_ready", 1'b1, h2d_ready);
            check_flag("reset link_busy", 1'b0, link_busy);
        end
        rst   = 1'b0;
        cycle = 0;
        done  = 1'b0;
        while (!done) begin
            @(posedge clk);
            #0.5;
            check_outputs();
            if (host_fis == NUM_FIS && link_fis == NUM_FIS && !status_due &&
                tx_q.size() == 0 && rx_q.size() == 0) begin
                done = 1'b1;
            end else begin
                if (cycle % 1024 == 0) begin
                    strobe_pct = pick_rate();
                    ready_pct  = pick_rate();
                end
                if (host_fis == NUM_FIS && link_fis == NUM_FIS) begin
                    strobe_pct = 100;               // drain both sides
                    ready_pct  = 100;
                end
                drive_host();
                drive_tx_side();
                drive_link();
                cycle++;
            end
        end
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
